//--- design/isaPkg.sv
package isaPkg;

	// ------------------------------------------------
	// Word and field sizes
	// ------------------------------------------------
	localparam int DATA_WIDTH      = 32;
	localparam int REG_ADDR_WIDTH  = 5;
	localparam int NUM_REGS        = 32;
	localparam int DMEM_ADDR_WIDTH = 8;

	localparam int OPCODE_WIDTH = 6;
	localparam int FUNCT_WIDTH  = 6;
	localparam int SHAMT_WIDTH  = 5;
	localparam int IMM_WIDTH    = 16;

	// Primary opcodes, instruction bits 31:26
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [FUNCT_WIDTH-1:0] {
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluOp_e;

endpackage

//--- design/pipePkg.sv
package pipePkg;

	import isaPkg::*;

	// Decoded control that follows an instruction down the pipe
	typedef struct packed {
		aluOp_e                    aluOp;
		logic                      useImm;
		logic                      useShamt;
		logic                      memRead;
		logic                      memWrite;
		logic                      regWrite;
		logic [REG_ADDR_WIDTH-1:0] dest;
	} ctrl_t;

	// ------------------------------------------------
	// Stage registers
	// ------------------------------------------------
	typedef struct packed {
		logic                      valid;
		ctrl_t                     ctrl;
		logic [REG_ADDR_WIDTH-1:0] rs;
		logic [REG_ADDR_WIDTH-1:0] rt;
		logic [DATA_WIDTH-1:0]     rsData;
		logic [DATA_WIDTH-1:0]     rtData;
		logic [DATA_WIDTH-1:0]     imm;
		logic [SHAMT_WIDTH-1:0]    shamt;
	} idEx_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [DATA_WIDTH-1:0] result;
		logic [DATA_WIDTH-1:0] storeData;
	} exMem_t;

	// Memory-to-writeback register, also the core's output record
	typedef struct packed {
		logic                      valid;
		logic                      writeEnable;
		logic [REG_ADDR_WIDTH-1:0] dest;
		logic [DATA_WIDTH-1:0]     data;
	} wbPort_t;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwdSel_e;

endpackage

//--- design/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit
	import isaPkg::*, pipePkg::*;
(
	input  logic [DATA_WIDTH-1:0] i_instr,
	output ctrl_t                 o_ctrl,
	output logic [DATA_WIDTH-1:0] o_imm
);

	logic [OPCODE_WIDTH-1:0]   opcode;
	logic [FUNCT_WIDTH-1:0]    funct;
	logic [REG_ADDR_WIDTH-1:0] rt;
	logic [REG_ADDR_WIDTH-1:0] rd;
	logic [IMM_WIDTH-1:0]      rawImm;

	assign opcode = i_instr[31:26];
	assign funct  = i_instr[5:0];
	assign rt     = i_instr[20:16];
	assign rd     = i_instr[15:11];
	assign rawImm = i_instr[15:0];

	always_comb
	begin
		// Unknown encodings fall through as a no-op
		o_ctrl       = '0;
		o_ctrl.aluOp = ALU_ADD;
		o_imm        = {{(DATA_WIDTH-IMM_WIDTH){rawImm[IMM_WIDTH-1]}}, rawImm};

		case (opcode)
			OP_RTYPE:
			begin
				o_ctrl.dest     = rd;
				o_ctrl.regWrite = 1'b1;
				case (funct)
					FN_ADD: o_ctrl.aluOp = ALU_ADD;
					FN_SUB: o_ctrl.aluOp = ALU_SUB;
					FN_AND: o_ctrl.aluOp = ALU_AND;
					FN_OR:  o_ctrl.aluOp = ALU_OR;
					FN_SLT: o_ctrl.aluOp = ALU_SLT;
					FN_SLL:
					begin
						o_ctrl.aluOp    = ALU_SLL;
						o_ctrl.useShamt = 1'b1;
					end
					default: o_ctrl.regWrite = 1'b0;
				endcase
			end
			OP_ADDI, OP_ORI, OP_LUI, OP_LW:
			begin
				o_ctrl.dest     = rt;
				o_ctrl.regWrite = 1'b1;
				o_ctrl.useImm   = 1'b1;
				o_ctrl.memRead  = (opcode == OP_LW);
				if (opcode == OP_ORI)
					o_ctrl.aluOp = ALU_OR;
				else if (opcode == OP_LUI)
					o_ctrl.aluOp = ALU_LUI;
				// Logical immediates are zero extended
				if (opcode == OP_ORI || opcode == OP_LUI)
					o_imm = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, rawImm};
			end
			OP_SW:
			begin
				o_ctrl.useImm   = 1'b1;
				o_ctrl.memWrite = 1'b1;
			end
			default:
			begin
				o_ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile
	import isaPkg::*, pipePkg::*;
(
	input  logic                      clock,
	input  logic                      i_reset,
	input  logic [REG_ADDR_WIDTH-1:0] i_rsAddr,
	input  logic [REG_ADDR_WIDTH-1:0] i_rtAddr,
	input  wbPort_t                   i_wb,
	output logic [DATA_WIDTH-1:0]     o_rsData,
	output logic [DATA_WIDTH-1:0]     o_rtData
);

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];
	logic                  doWrite;

	assign doWrite = i_wb.valid && i_wb.writeEnable;

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (doWrite)
			regs[i_wb.dest] <= i_wb.data;
	end

	// Same-cycle write is visible to the reader
	assign o_rsData = (i_rsAddr == '0) ? '0 :
		(doWrite && i_wb.dest == i_rsAddr) ? i_wb.data : regs[i_rsAddr];
	assign o_rtData = (i_rtAddr == '0) ? '0 :
		(doWrite && i_wb.dest == i_rtAddr) ? i_wb.data : regs[i_rtAddr];

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
	import isaPkg::*, pipePkg::*;
(
	input  logic [REG_ADDR_WIDTH-1:0] i_idRs,
	input  logic [REG_ADDR_WIDTH-1:0] i_idRt,
	input  idEx_t                     i_idEx,
	input  exMem_t                    i_exMem,
	input  wbPort_t                   i_memWb,
	output fwdSel_e                   o_fwdA,
	output fwdSel_e                   o_fwdB,
	output logic                      o_stall
);

	logic memWrites;
	logic wbWrites;

	assign memWrites = i_exMem.valid && i_exMem.ctrl.regWrite && (i_exMem.ctrl.dest != '0);
	assign wbWrites  = i_memWb.valid && i_memWb.writeEnable && (i_memWb.dest != '0);

	// Youngest producer wins
	always_comb
	begin
		if (memWrites && i_exMem.ctrl.dest == i_idEx.rs)
			o_fwdA = FWD_MEM;
		else if (wbWrites && i_memWb.dest == i_idEx.rs)
			o_fwdA = FWD_WB;
		else
			o_fwdA = FWD_REG;

		if (memWrites && i_exMem.ctrl.dest == i_idEx.rt)
			o_fwdB = FWD_MEM;
		else if (wbWrites && i_memWb.dest == i_idEx.rt)
			o_fwdB = FWD_WB;
		else
			o_fwdB = FWD_REG;
	end

	// Load data is not ready until the memory stage ends
	assign o_stall = i_idEx.valid && i_idEx.ctrl.memRead && (i_idEx.ctrl.dest != '0)
		&& (i_idEx.ctrl.dest == i_idRs || i_idEx.ctrl.dest == i_idRt);

endmodule

//--- design/execUnit.sv
`timescale 1ns/1ps

module execUnit
	import isaPkg::*, pipePkg::*;
(
	input  idEx_t                 i_idEx,
	input  fwdSel_e               i_fwdA,
	input  fwdSel_e               i_fwdB,
	input  logic [DATA_WIDTH-1:0] i_memResult,
	input  logic [DATA_WIDTH-1:0] i_wbData,
	output exMem_t                o_exMem
);

	logic [DATA_WIDTH-1:0] rsVal;
	logic [DATA_WIDTH-1:0] rtVal;
	logic [DATA_WIDTH-1:0] opA;
	logic [DATA_WIDTH-1:0] opB;
	logic [DATA_WIDTH-1:0] result;

	always_comb
	begin
		case (i_fwdA)
			FWD_MEM: rsVal = i_memResult;
			FWD_WB:  rsVal = i_wbData;
			default: rsVal = i_idEx.rsData;
		endcase
		case (i_fwdB)
			FWD_MEM: rtVal = i_memResult;
			FWD_WB:  rtVal = i_wbData;
			default: rtVal = i_idEx.rtData;
		endcase
	end

	// sll takes shamt on A and rt on B
	assign opA = i_idEx.ctrl.useShamt ?
		{{(DATA_WIDTH-SHAMT_WIDTH){1'b0}}, i_idEx.shamt} : rsVal;
	assign opB = i_idEx.ctrl.useImm ? i_idEx.imm : rtVal;

	// ------------------------------------------------
	// ALU
	// ------------------------------------------------
	always_comb
	begin
		case (i_idEx.ctrl.aluOp)
			ALU_ADD: result = opA + opB;
			ALU_SUB: result = opA - opB;
			ALU_AND: result = opA & opB;
			ALU_OR:  result = opA | opB;
			ALU_SLT: result = {{(DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
			ALU_SLL: result = opB << opA[SHAMT_WIDTH-1:0];
			ALU_LUI: result = opB << IMM_WIDTH;
			default: result = '0;
		endcase
	end

	assign o_exMem.valid     = i_idEx.valid;
	assign o_exMem.ctrl      = i_idEx.ctrl;
	assign o_exMem.result    = result;
	assign o_exMem.storeData = rtVal;

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
	import isaPkg::*, pipePkg::*;
(
	input  logic                  clock,
	input  exMem_t                i_exMem,
	output logic [DATA_WIDTH-1:0] o_readData
);

	logic [DATA_WIDTH-1:0]      ram [2**DMEM_ADDR_WIDTH];
	logic [DMEM_ADDR_WIDTH-1:0] wordAddr;

	// Byte address to word index
	assign wordAddr = i_exMem.result[DMEM_ADDR_WIDTH+1:2];

	always_ff @(posedge clock)
	begin
		if (i_exMem.valid && i_exMem.ctrl.memWrite)
			ram[wordAddr] <= i_exMem.storeData;
	end

	assign o_readData = ram[wordAddr];

endmodule

//--- design/perfCounters.sv
`timescale 1ns/1ps

module perfCounters
	import isaPkg::*;
(
	input  logic                  clock,
	input  logic                  i_reset,
	input  logic                  i_retire,
	output logic [DATA_WIDTH-1:0] o_cycleCount,
	output logic [DATA_WIDTH-1:0] o_retireCount
);

	// Both wrap silently
	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			o_cycleCount  <= '0;
			o_retireCount <= '0;
		end
		else
		begin
			o_cycleCount <= o_cycleCount + 1'b1;
			if (i_retire)
				o_retireCount <= o_retireCount + 1'b1;
		end
	end

endmodule

//--- design/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline
	import isaPkg::*, pipePkg::*;
(
	input  logic                  clock,
	input  logic                  i_reset,
	input  logic [DATA_WIDTH-1:0] i_instr,
	input  logic                  i_instrValid,
	output logic                  o_instrReady,
	output wbPort_t               o_wb,
	output logic [DATA_WIDTH-1:0] o_cycleCount,
	output logic [DATA_WIDTH-1:0] o_retireCount
);

	logic                      ifIdValid;
	logic [DATA_WIDTH-1:0]     ifIdInstr;
	logic [REG_ADDR_WIDTH-1:0] idRs;
	logic [REG_ADDR_WIDTH-1:0] idRt;
	ctrl_t                     decCtrl;
	logic [DATA_WIDTH-1:0]     decImm;
	logic [DATA_WIDTH-1:0]     rsData;
	logic [DATA_WIDTH-1:0]     rtData;
	logic                      stall;
	fwdSel_e                   fwdA;
	fwdSel_e                   fwdB;
	logic [DATA_WIDTH-1:0]     memReadData;

	idEx_t   idEx;
	idEx_t   idExNext;
	exMem_t  exMem;
	exMem_t  exMemNext;
	wbPort_t memWb;
	wbPort_t memWbNext;

	// ------------------------------------------------
	// Fetch-accept
	// ------------------------------------------------
	assign o_instrReady = !stall;

	always_ff @(posedge clock)
	begin
		if (i_reset)
			ifIdValid <= 1'b0;
		else if (!stall)
			ifIdValid <= i_instrValid;
	end

	always_ff @(posedge clock)
	begin
		if (!stall)
			ifIdInstr <= i_instr;
	end

	// ------------------------------------------------
	// Decode
	// ------------------------------------------------
	// Idle slots read r0 so they never look like a hazard
	assign idRs = ifIdValid ? ifIdInstr[25:21] : '0;
	assign idRt = ifIdValid ? ifIdInstr[20:16] : '0;

	decodeUnit u_decodeUnit (
		.i_instr (ifIdInstr),
		.o_ctrl  (decCtrl),
		.o_imm   (decImm)
	);

	regFile u_regFile (
		.clock    (clock),
		.i_reset  (i_reset),
		.i_rsAddr (idRs),
		.i_rtAddr (idRt),
		.i_wb     (memWb),
		.o_rsData (rsData),
		.o_rtData (rtData)
	);

	hazardUnit u_hazardUnit (
		.i_idRs  (idRs),
		.i_idRt  (idRt),
		.i_idEx  (idEx),
		.i_exMem (exMem),
		.i_memWb (memWb),
		.o_fwdA  (fwdA),
		.o_fwdB  (fwdB),
		.o_stall (stall)
	);

	// Bubble into execute while the load-use stall holds decode
	always_comb
	begin
		idExNext.valid  = ifIdValid && !stall;
		idExNext.ctrl   = idExNext.valid ? decCtrl : '0;
		idExNext.rs     = idRs;
		idExNext.rt     = idRt;
		idExNext.rsData = rsData;
		idExNext.rtData = rtData;
		idExNext.imm    = decImm;
		idExNext.shamt  = ifIdInstr[10:6];
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			idEx.valid <= 1'b0;
			idEx.ctrl  <= '0;
		end
		else
			idEx <= idExNext;
	end

	// ------------------------------------------------
	// Execute
	// ------------------------------------------------
	execUnit u_execUnit (
		.i_idEx      (idEx),
		.i_fwdA      (fwdA),
		.i_fwdB      (fwdB),
		.i_memResult (exMem.result),
		.i_wbData    (memWb.data),
		.o_exMem     (exMemNext)
	);

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			exMem.valid <= 1'b0;
			exMem.ctrl  <= '0;
		end
		else
			exMem <= exMemNext;
	end

	// ------------------------------------------------
	// Memory and writeback
	// ------------------------------------------------
	dataMemory u_dataMemory (
		.clock      (clock),
		.i_exMem    (exMem),
		.o_readData (memReadData)
	);

	always_comb
	begin
		memWbNext.valid       = exMem.valid;
		memWbNext.writeEnable = exMem.valid && exMem.ctrl.regWrite && (exMem.ctrl.dest != '0);
		memWbNext.dest        = exMem.ctrl.dest;
		memWbNext.data        = exMem.ctrl.memRead ? memReadData : exMem.result;
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			memWb.valid       <= 1'b0;
			memWb.writeEnable <= 1'b0;
		end
		else
			memWb <= memWbNext;
	end

	assign o_wb = memWb;

	perfCounters u_perfCounters (
		.clock         (clock),
		.i_reset       (i_reset),
		.i_retire      (memWb.valid),
		.o_cycleCount  (o_cycleCount),
		.o_retireCount (o_retireCount)
	);

endmodule

//--- verification/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------------------------
// Architectural model state
// ------------------------------------------------
logic [DATA_WIDTH-1:0]     modelRegs [NUM_REGS];
logic [DATA_WIDTH-1:0]     modelMem [2**DMEM_ADDR_WIDTH];
logic [REG_ADDR_WIDTH-1:0] recentDest [2];
int                        storedWords [$];

function automatic void resetModel();
	foreach (modelRegs[i])
		modelRegs[i] = '0;
	recentDest[0] = '0;
	recentDest[1] = '0;
	storedWords.delete();
endfunction

// Runs one instruction to completion, returns the record it must retire as
function automatic wbPort_t refExecute(input logic [DATA_WIDTH-1:0] instr);
	wbPort_t                   expected;
	logic [DATA_WIDTH-1:0]     rsVal;
	logic [DATA_WIDTH-1:0]     rtVal;
	logic [DATA_WIDTH-1:0]     sImm;
	logic [DATA_WIDTH-1:0]     zImm;
	logic [DATA_WIDTH-1:0]     addr;
	logic [DATA_WIDTH-1:0]     value;
	logic [REG_ADDR_WIDTH-1:0] dest;
	logic                      writes;
	rsVal  = modelRegs[instr[25:21]];
	rtVal  = modelRegs[instr[20:16]];
	sImm   = {{16{instr[15]}}, instr[15:0]};
	zImm   = {16'h0000, instr[15:0]};
	addr   = rsVal + sImm;
	dest   = instr[20:16];
	writes = 1'b1;
	value  = '0;
	case (instr[31:26])
		OP_RTYPE:
		begin
			dest = instr[15:11];
			case (instr[5:0])
				FN_ADD: value = rsVal + rtVal;
				FN_SUB: value = rsVal - rtVal;
				FN_AND: value = rsVal & rtVal;
				FN_OR:  value = rsVal | rtVal;
				FN_SLT: value = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
				FN_SLL: value = rtVal << instr[10:6];
				default: writes = 1'b0;
			endcase
		end
		OP_ADDI: value = rsVal + sImm;
		OP_ORI:  value = rsVal | zImm;
		OP_LUI:  value = {instr[15:0], 16'h0000};
		// Word index is byte address bits 9:2
		OP_LW:   value = modelMem[addr[9:2]];
		OP_SW:
		begin
			writes = 1'b0;
			modelMem[addr[9:2]] = rtVal;
		end
		default: writes = 1'b0;
	endcase
	expected.valid       = 1'b1;
	expected.writeEnable = writes && (dest != '0);
	expected.dest        = dest;
	expected.data        = value;
	if (expected.writeEnable)
	begin
		modelRegs[dest] = value;
		recentDest[1]   = recentDest[0];
		recentDest[0]   = dest;
	end
	return expected;
endfunction

// ------------------------------------------------
// Instruction generators
// ------------------------------------------------
function automatic int randBelow(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [REG_ADDR_WIDTH-1:0] randReg();
	return 5'(randBelow(NUM_REGS));
endfunction

// Half the sources hit one of the two latest results
function automatic logic [REG_ADDR_WIDTH-1:0] pickSrc();
	if (randBelow(2) == 0)
		return recentDest[randBelow(2)];
	else
		return randReg();
endfunction

function automatic logic [31:0] makeR(input funct_e funct, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
	return {OP_RTYPE, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] makeI(input opcode_e op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic funct_e randFunct();
	case (randBelow(6))
		0:       return FN_ADD;
		1:       return FN_SUB;
		2:       return FN_AND;
		3:       return FN_OR;
		4:       return FN_SLT;
		default: return FN_SLL;
	endcase
endfunction

function automatic logic [31:0] genRtype();
	return makeR(randFunct(), pickSrc(), pickSrc(), randReg(), 5'(randBelow(32)));
endfunction

// Register 0 gets picked as target about one time in six
function automatic logic [31:0] genImm();
	opcode_e                   op;
	logic [REG_ADDR_WIDTH-1:0] rt;
	case (randBelow(3))
		0:       op = OP_ADDI;
		1:       op = OP_ORI;
		default: op = OP_LUI;
	endcase
	rt = (randBelow(6) == 0) ? 5'd0 : randReg();
	return makeI(op, pickSrc(), rt, 16'(randBelow(65536)));
endfunction

// Base is r0, so the offset is the byte address
function automatic logic [31:0] genStore();
	int word;
	word = randBelow(2**DMEM_ADDR_WIDTH);
	storedWords.push_back(word);
	return makeI(OP_SW, 5'd0, randReg(), 16'(word * 4));
endfunction

function automatic logic [31:0] genLoad(input logic [REG_ADDR_WIDTH-1:0] dest);
	int word;
	word = storedWords[randBelow(storedWords.size())];
	return makeI(OP_LW, 5'd0, dest, 16'(word * 4));
endfunction

`endif

//--- verification/mipsPipelineTb.sv
`timescale 1ns/1ps

module mipsPipelineTb
	import isaPkg::*, pipePkg::*;
();

	localparam int CLK_PERIOD       = 8;
	localparam int RESET_CYCLES     = 8;
	localparam int SEED_INSTRS      = 62;
	localparam int RTYPE_INSTRS     = 200;
	localparam int IMM_INSTRS       = 100;
	localparam int MEM_GROUPS       = 50;
	localparam int GAP_INSTRS       = 150;
	localparam int TOTAL_INSTRS     = SEED_INSTRS + RTYPE_INSTRS + IMM_INSTRS
		+ 3 * MEM_GROUPS + GAP_INSTRS;
	localparam int CYCLES_PER_INSTR = 20;
	localparam int DRAIN_CYCLES     = 12;

	logic                  clock;
	logic                  i_reset;
	logic [DATA_WIDTH-1:0] i_instr;
	logic                  i_instrValid;
	logic                  o_instrReady;
	wbPort_t               o_wb;
	logic [DATA_WIDTH-1:0] o_cycleCount;
	logic [DATA_WIDTH-1:0] o_retireCount;

	int      seed = 99;
	wbPort_t expQ [$];
	int      errorCount;
	int      checksRun;
	int      acceptCount;
	int      stallCycles;

	`include "tbRefModel.svh"

	mipsPipeline i_mipsPipeline (
		.clock         (clock),
		.i_reset       (i_reset),
		.i_instr       (i_instr),
		.i_instrValid  (i_instrValid),
		.o_instrReady  (o_instrReady),
		.o_wb          (o_wb),
		.o_cycleCount  (o_cycleCount),
		.o_retireCount (o_retireCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial
	begin
		#((RESET_CYCLES + CYCLES_PER_INSTR * TOTAL_INSTRS) * CLK_PERIOD);
		$display("Watchdog expired at %0t, the run timed out before the tests ended", $time);
		$display("Simulation failed");
		$finish;
	end

	// ------------------------------------------------
	// Checks
	// ------------------------------------------------
	// dest and data only matter when a register is written
	task automatic checkWb(input wbPort_t expected, input wbPort_t actual);
		checksRun++;
		if (actual.writeEnable !== expected.writeEnable)
		begin
			errorCount++;
			$display("FAILED at %0t: o_wb.writeEnable expected %b got %b", $time,
				expected.writeEnable, actual.writeEnable);
		end
		else if (expected.writeEnable && actual.dest !== expected.dest)
		begin
			errorCount++;
			$display("FAILED at %0t: o_wb.dest expected %0d got %0d", $time,
				expected.dest, actual.dest);
		end
		else if (expected.writeEnable && actual.data !== expected.data)
		begin
			errorCount++;
			$display("FAILED at %0t: o_wb.data expected %h got %h", $time,
				expected.data, actual.data);
		end
	endtask

	task automatic checkCount(input string name, input logic [DATA_WIDTH-1:0] actual,
		input logic [DATA_WIDTH-1:0] expected);
		checksRun++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checksRun++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clock)
	begin
		if (!i_reset)
		begin
			if (!o_instrReady)
				stallCycles++;
			if (o_wb.valid)
			begin
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("Writeback record at %0t with no instruction outstanding", $time);
				end
				else
					checkWb(expQ.pop_front(), o_wb);
			end
		end
	end

	// ------------------------------------------------
	// Stimulus
	// ------------------------------------------------
	// Ready depends only on pipeline state, so it is final at the falling edge
	task automatic sendInstr(input logic [DATA_WIDTH-1:0] instr);
		@(negedge clock);
		i_instr      = instr;
		i_instrValid = 1'b1;
		while (!o_instrReady)
			@(negedge clock);
		expQ.push_back(refExecute(instr));
		acceptCount++;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge clock);
			i_instrValid = 1'b0;
			i_instr      = $random(seed);
		end
	endtask

	task automatic drain();
		@(negedge clock);
		i_instrValid = 1'b0;
		for (int i = 0; i < DRAIN_CYCLES && expQ.size() != 0; i++)
			@(negedge clock);
		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("%0d expected records never showed up on o_wb", expQ.size());
			expQ.delete();
		end
		@(negedge clock);
	endtask

	task automatic reportTest(input int num, input string name, input int errorsBefore);
		$display("Test %0d %-22s %s  (errors %0d, accepted so far %0d)", num, name,
			(errorCount == errorsBefore) ? "PASS" : "FAIL", errorCount - errorsBefore,
			acceptCount);
	endtask

	initial
	begin
		int                        errorsBefore;
		int                        stallsBefore;
		logic [REG_ADDR_WIDTH-1:0] loadDest;
		i_reset      = 1'b1;
		i_instr      = '0;
		i_instrValid = 1'b0;
		errorCount   = 0;
		checksRun    = 0;
		acceptCount  = 0;
		stallCycles  = 0;
		resetModel();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		i_reset = 1'b0;

		// Reset state
		errorsBefore = errorCount;
		checkFlag("o_wb.valid", o_wb.valid, 1'b0);
		checkFlag("o_instrReady", o_instrReady, 1'b1);
		checkCount("o_cycleCount", o_cycleCount, 0);
		checkCount("o_retireCount", o_retireCount, 0);
		reportTest(1, "reset state", errorsBefore);

		// Give every register a random value, then R-type back to back
		errorsBefore = errorCount;
		for (int r = 1; r < NUM_REGS; r++)
		begin
			sendInstr(makeI(OP_LUI, 5'd0, 5'(r), 16'(randBelow(65536))));
			sendInstr(makeI(OP_ORI, 5'(r), 5'(r), 16'(randBelow(65536))));
		end
		for (int n = 0; n < RTYPE_INSTRS; n++)
			sendInstr(genRtype());
		drain();
		reportTest(2, "rtype forwarding", errorsBefore);

		errorsBefore = errorCount;
		for (int n = 0; n < IMM_INSTRS; n++)
			sendInstr(genImm());
		drain();
		reportTest(3, "immediates", errorsBefore);

		// Store, load, then a consumer of the load right behind it
		errorsBefore = errorCount;
		stallsBefore = stallCycles;
		for (int n = 0; n < MEM_GROUPS; n++)
		begin
			sendInstr(genStore());
			loadDest = 5'(1 + randBelow(NUM_REGS - 1));
			sendInstr(genLoad(loadDest));
			sendInstr(makeR(randFunct(), loadDest, randReg(), randReg(), 5'(randBelow(32))));
		end
		drain();
		checkCount("o_retireCount", o_retireCount, acceptCount);
		if (stallCycles == stallsBefore)
		begin
			errorCount++;
			$display("o_instrReady never dropped during the load-use sequence");
		end
		reportTest(4, "loads and stores", errorsBefore);

		errorsBefore = errorCount;
		for (int n = 0; n < GAP_INSTRS; n++)
		begin
			if (randBelow(3) == 0)
				idleCycles(1 + randBelow(3));
			case (randBelow(4))
				0:       sendInstr(genRtype());
				1:       sendInstr(genImm());
				2:       sendInstr(genStore());
				default: sendInstr(genLoad(randReg()));
			endcase
		end
		drain();
		checkCount("o_retireCount", o_retireCount, acceptCount);
		if (o_cycleCount < acceptCount)
		begin
			errorCount++;
			$display("o_cycleCount %0d is below the %0d accepted instructions",
				o_cycleCount, acceptCount);
		end
		reportTest(5, "valid gaps", errorsBefore);

		$display("Tests 5, checks %0d, errors %0d", checksRun, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+verification
design/isaPkg.sv
design/pipePkg.sv
design/decodeUnit.sv
design/regFile.sv
design/hazardUnit.sv
design/execUnit.sv
design/dataMemory.sv
design/perfCounters.sv
design/mipsPipeline.sv
verification/mipsPipelineTb.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - design/isaPkg.sv
  - design/pipePkg.sv
  - design/decodeUnit.sv
  - design/regFile.sv
  - design/hazardUnit.sv
  - design/execUnit.sv
  - design/dataMemory.sv
  - design/perfCounters.sv
  - design/mipsPipeline.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/mipsPipelineTb.sv
